// File: sim.f
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;

    import eeprom_pkg::*;

    localparam int DONE_TIMEOUT = 2000;

    logic       CLK = 1'b0;
    logic       RESET;
    logic       wr;
    logic       rd;
    ee_addr_t   addr;
    ee_byte_t   wdata;
    ee_byte_t   rdata;
    logic       busy;
    logic       done;
    logic       nack;
    logic       scl;
    wire        sda;
    logic       force_nack;

    ee_byte_t   shadow [0:2047];
    logic       written [0:2047];
    ee_addr_t   addr_list [$];
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    logic       timed_out = 1'b0;

    pullup (sda);

    always #20 CLK = ~CLK;

    eeprom_ctrl_top u_eeprom_ctrl_top (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .busy   (busy),
        .done   (done),
        .nack   (nack),
        .scl    (scl),
        .sda    (sda)
    );

    eeprom_model u_eeprom_model (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack)
    );

    // expected contents of the slave memory
    function automatic ee_byte_t ref_read(input ee_addr_t a);
        return shadow[a];
    endfunction

    task automatic check_op(input string name, input logic exp_nack,
                            input ee_byte_t exp_data, input logic use_data);
        if (busy !== 1'b0)
        begin
            $display("Fail %s: expected busy 0, actual %b", name, busy);
            fail_cnt++;
        end
        else if (nack !== exp_nack)
        begin
            $display("Fail %s: expected nack %b, actual %b", name, exp_nack, nack);
            fail_cnt++;
        end
        else if (use_data && (rdata !== exp_data))
        begin
            $display("Fail %s: expected %h, actual %h", name, exp_data, rdata);
            fail_cnt++;
        end
        else
        begin
            $display("Pass %s", name);
            pass_cnt++;
        end
    endtask

    task automatic strobe(input logic is_wr, input ee_addr_t a, input ee_byte_t d);
        @(posedge CLK);
        #2;
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done(input string name, output logic seen);
        seen = 1'b0;
        for (int i = 0; (i < DONE_TIMEOUT) && !seen; i++)
        begin
            @(negedge CLK);
            seen = done;
        end
        if (!seen)
        begin
            $display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
            fail_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic write_byte(input string name, input ee_addr_t a, input ee_byte_t d,
                              input logic exp_nack);
        logic seen;
        if (timed_out)
            return;
        strobe(1'b1, a, d);
        wait_done(name, seen);
        if (seen)
            check_op(name, exp_nack, 8'h00, 1'b0);
        if (!exp_nack)
        begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic read_byte(input string name, input ee_addr_t a);
        logic seen;
        if (timed_out)
            return;
        strobe(1'b0, a, 8'h00);
        wait_done(name, seen);
        if (seen)
            check_op(name, 1'b0, ref_read(a), 1'b1);
    endtask

    initial
    begin
        int         seed_val;
        int         j;
        int         done_cnt;
        logic       busy_seen;
        logic       last_nack;
        ee_addr_t   a;
        ee_addr_t   b;
        ee_byte_t   d;

        seed_val   = $urandom(22);
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        force_nack = 1'b0;
        for (int i = 0; i < 2048; i++)
        begin
            shadow[i]  = 8'hFF;
            written[i] = 1'b0;
        end
        repeat (4) @(posedge CLK);
        #2;
        RESET = 1'b0;

        @(negedge CLK);
        if ({busy, done, nack, scl, sda} !== 5'b00011)
        begin
            $display("Fail reset_state: expected 00011, actual %b", {busy, done, nack, scl, sda});
            fail_cnt++;
        end
        else
        begin
            $display("Pass reset_state");
            pass_cnt++;
        end

        write_byte("single_write", 11'h1A5, 8'h5A, 1'b0);
        read_byte("single_read", 11'h1A5);

        // spread over all eight blocks
        for (int i = 0; i < 20; i++)
        begin
            a = {3'(i % 8), 8'($urandom)};
            d = 8'($urandom);
            addr_list.push_back(a);
            write_byte($sformatf("rand_write_%03h", a), a, d, 1'b0);
        end
        for (int i = addr_list.size() - 1; i > 0; i--)
        begin
            j = int'($urandom_range(i, 0));
            a = addr_list[i];
            addr_list[i] = addr_list[j];
            addr_list[j] = a;
        end
        foreach (addr_list[i])
            read_byte($sformatf("rand_read_%03h", addr_list[i]), addr_list[i]);

        a = 11'h7FF;
        while (written[a])
            a = a - 11'd1;
        read_byte("unwritten_read", a);

        a = addr_list[0];
        @(posedge CLK);
        #2;
        force_nack = 1'b1;
        write_byte("nack_write", a, ~ref_read(a), 1'b1);
        @(posedge CLK);
        #2;
        force_nack = 1'b0;
        read_byte("read_after_nack", a);

        // second strobe lands while the first write is in flight
        a = 11'h233;
        b = a ^ 11'h400;
        d = ~ref_read(a);
        strobe(1'b1, a, d);
        @(negedge CLK);
        busy_seen = busy;   // one cycle after the strobe
        strobe(1'b1, b, ~ref_read(b));
        done_cnt  = 0;
        last_nack = 1'b1;
        for (int i = 0; i < DONE_TIMEOUT; i++)
        begin
            @(negedge CLK);
            if (done)
            begin
                done_cnt++;
                last_nack = nack;
            end
        end
        if (!busy_seen)
        begin
            $display("Fail busy_strobe: expected busy 1, actual 0");
            fail_cnt++;
        end
        else if (done_cnt != 1)
        begin
            $display("Fail busy_strobe: expected 1, actual %0d", done_cnt);
            fail_cnt++;
        end
        else if (last_nack !== 1'b0)
        begin
            $display("Fail busy_strobe: expected nack 0, actual %b", last_nack);
            fail_cnt++;
        end
        else
        begin
            $display("Pass busy_strobe");
            pass_cnt++;
        end
        shadow[a] = d;
        read_byte("busy_first_read", a);
        read_byte("busy_ignored_read", b);

        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  wire     CLK,
    input  wire     scl,
    inout  wire     sda,
    input  wire     force_nack
);

    logic [7:0]     mem [0:2047];
    logic           drv_low;
    logic           scl_q;
    logic           sda_q;
    logic           active;
    logic           sending;
    logic           send_next;   // more read data owed after the ack slot
    logic           ack;
    logic [3:0]     bit_cnt;
    logic [1:0]     byte_idx;
    logic [2:0]     block;
    logic [10:0]    ptr;
    logic [7:0]     shreg;

    assign sda = drv_low ? 1'b0 : 1'bz;

    // bus sampled on falling CLK, scl and sda are steady there
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        drv_low   = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        active    = 1'b0;
        sending   = 1'b0;
        send_next = 1'b0;
        ack       = 1'b0;
        bit_cnt   = 4'd0;
        byte_idx  = 2'd0;
        block     = 3'd0;
        ptr       = 11'd0;
        shreg     = 8'd0;
        forever
        begin
            @(negedge CLK);
            if (scl && scl_q && sda_q && !sda)
            begin
                active    = 1'b1;   // start or repeated start
                bit_cnt   = 4'd0;
                byte_idx  = 2'd0;
                sending   = 1'b0;
                send_next = 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                active  = 1'b0;     // stop
                drv_low = 1'b0;
            end
            else if (active && scl && !scl_q)
            begin
                if ((bit_cnt < 4'd8) && !sending)
                    shreg = {shreg[6:0], sda};
                if ((bit_cnt == 4'd8) && sending)
                begin
                    if (sda)
                        send_next = 1'b0;   // master nack ends the read
                    else
                        ptr = ptr + 11'd1;
                end
                bit_cnt = bit_cnt + 4'd1;
            end
            else if (active && !scl && scl_q)
            begin
                if (bit_cnt == 4'd9)
                begin
                    bit_cnt = 4'd0;
                    drv_low = 1'b0;
                    sending = send_next;
                    if (send_next)
                    begin
                        shreg   = mem[ptr];
                        drv_low = !shreg[7];
                    end
                end
                else if (bit_cnt == 4'd8)
                begin
                    if (sending)
                        drv_low = 1'b0;   // let the master answer
                    else
                    begin
                        ack = 1'b1;
                        case (byte_idx)
                            2'd0:
                            begin
                                if (shreg[7:4] != 4'b1010)
                                    ack = 1'b0;
                                block     = shreg[3:1];
                                send_next = shreg[0];
                            end
                            2'd1:
                            begin
                                if (force_nack)
                                    ack = 1'b0;
                                else
                                    ptr = {block, shreg};
                            end
                            default: mem[ptr] = shreg;
                        endcase
                        if (byte_idx != 2'd3)
                            byte_idx = byte_idx + 2'd1;
                        drv_low = ack;
                        if (!ack)
                            active = 1'b0;   // deaf until the next start
                    end
                end
                else if (sending)
                begin
                    shreg   = {shreg[6:0], 1'b0};
                    drv_low = !shreg[7];
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// File: design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         wr,
    input  wire                         rd,
    input  wire eeprom_pkg::ee_addr_t   addr,
    input  wire eeprom_pkg::ee_byte_t   wdata,
    output wire eeprom_pkg::ee_byte_t   rdata,
    output wire                         busy,
    output wire                         done,
    output wire                         nack,
    output wire                         scl,
    inout  wire                         sda
);

    import eeprom_pkg::*;

    wire            cmd_valid;
    bit_cmd_t       cmd;
    ee_byte_t       tx_byte;
    wire            tx_ack_bit;
    wire            cmd_done;
    ee_byte_t       rx_byte;
    wire            rx_ack;
    wire            sda_low;

    // open drain, pull-up sits outside the chip
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_sequencer u_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .rx_ack     (rx_ack),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .tx_ack_bit (tx_ack_bit),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .nack       (nack)
    );

    i2c_bit_engine u_bit_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .tx_ack_bit (tx_ack_bit),
        .sda_in     (sda),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .rx_ack     (rx_ack),
        .scl        (scl),
        .sda_low    (sda_low)
    );

endmodule

`default_nettype wire

// File: design/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         wr,
    input  wire                         rd,
    input  wire eeprom_pkg::ee_addr_t   addr,
    input  wire eeprom_pkg::ee_byte_t   wdata,
    input  wire                         cmd_done,
    input  wire eeprom_pkg::ee_byte_t   rx_byte,
    input  wire                         rx_ack,
    output logic                        cmd_valid,
    output eeprom_pkg::bit_cmd_t        cmd,
    output eeprom_pkg::ee_byte_t        tx_byte,
    output logic                        tx_ack_bit,
    output eeprom_pkg::ee_byte_t        rdata,
    output logic                        busy,
    output logic                        done,
    output logic                        nack
);

    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR_WR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        FINISH
    } seq_state_t;

    seq_state_t state;
    ee_addr_t   addr_q;
    ee_byte_t   wdata_q;
    logic       is_rd;
    logic       cmd_wait;   // command issued, engine still working

    assign cmd_valid  = (state != IDLE) && (state != FINISH) && !cmd_wait;
    assign tx_ack_bit = 1'b1;   // one byte read, always NACK it

    always_comb
    begin
        cmd     = CMD_WRITE;
        tx_byte = '0;
        case (state)
            START,
            RESTART: cmd = CMD_START;
            STOP:    cmd = CMD_STOP;
            DATA_RD: cmd = CMD_READ;
            CTRL_WR: tx_byte = {CTRL_CODE, addr_q[10:8], 1'b0};
            CTRL_RD: tx_byte = {CTRL_CODE, addr_q[10:8], 1'b1};
            ADDR_WR: tx_byte = addr_q[7:0];
            DATA_WR: tx_byte = wdata_q;
            default: cmd = CMD_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            is_rd    <= 1'b0;
            cmd_wait <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (cmd_valid)
                cmd_wait <= 1'b1;
            else if (cmd_done)
                cmd_wait <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (wr || rd)
                    begin
                        is_rd <= !wr;   // write wins a tie
                        busy  <= 1'b1;
                        nack  <= 1'b0;
                        state <= START;
                    end
                end
                START:
                    if (cmd_done)
                        state <= CTRL_WR;
                CTRL_WR:
                begin
                    if (cmd_done)
                    begin
                        nack  <= rx_ack;
                        state <= rx_ack ? STOP : ADDR_WR;
                    end
                end
                ADDR_WR:
                begin
                    if (cmd_done)
                    begin
                        nack <= rx_ack;
                        if (rx_ack)
                            state <= STOP;   // skip the rest of the transfer
                        else
                            state <= is_rd ? RESTART : DATA_WR;
                    end
                end
                DATA_WR:
                begin
                    if (cmd_done)
                    begin
                        nack  <= rx_ack;
                        state <= STOP;
                    end
                end
                RESTART:
                    if (cmd_done)
                        state <= CTRL_RD;
                CTRL_RD:
                begin
                    if (cmd_done)
                    begin
                        nack  <= rx_ack;
                        state <= rx_ack ? STOP : DATA_RD;
                    end
                end
                DATA_RD:
                    if (cmd_done)
                        state <= STOP;
                STOP:
                    if (cmd_done)
                        state <= FINISH;
                default:
                begin
                    done  <= 1'b1;   // busy drops with done
                    busy  <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and read payload
    always_ff @(posedge CLK)
    begin
        if ((state == IDLE) && (wr || rd))
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if ((state == DATA_RD) && cmd_done)
            rdata <= rx_byte;
    end

endmodule

`default_nettype wire

// File: design/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         cmd_valid,
    input  wire eeprom_pkg::bit_cmd_t   cmd,
    input  wire eeprom_pkg::ee_byte_t   tx_byte,
    input  wire                         tx_ack_bit,
    input  wire                         sda_in,
    output logic                        cmd_done,
    output eeprom_pkg::ee_byte_t        rx_byte,
    output logic                        rx_ack,
    output logic                        scl,
    output logic                        sda_low
);

    import eeprom_pkg::*;

    logic                active;
    bit_cmd_t            cmd_q;
    logic [QTR_W-1:0]    qtr_cnt;
    logic [1:0]          qtr;       // quarter within the current bit
    logic [3:0]          bit_cnt;
    ee_byte_t            shift_q;   // out on [7], in on [0]
    logic                ack_q;
    logic                qtr_end;
    logic                last_bit;
    logic                is_byte;

    assign qtr_end  = active && (qtr_cnt == QTR_W'(QTR_CYCLES - 1));
    assign is_byte  = (cmd_q == CMD_WRITE) || (cmd_q == CMD_READ);
    // start and stop are a single bit time
    assign last_bit = is_byte ? (bit_cnt == 4'(ACK_BIT)) : 1'b1;

    // bus sequencing, scl high in quarters 2 and 3
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            cmd_q    <= CMD_STOP;
            qtr_cnt  <= '0;
            qtr      <= 2'd0;
            bit_cnt  <= 4'd0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    cmd_q   <= cmd;
                    qtr_cnt <= '0;
                    qtr     <= 2'd0;
                    bit_cnt <= 4'd0;
                    scl     <= 1'b0;
                end
            end
            else
            begin
                qtr_cnt <= qtr_end ? '0 : qtr_cnt + 1'b1;
                if (qtr_end)
                begin
                    qtr <= qtr + 2'd1;
                    case (qtr)
                        2'd0:
                        begin
                            // sda only moves in the middle of scl low
                            case (cmd_q)
                                CMD_START: sda_low <= 1'b0;
                                CMD_STOP:  sda_low <= 1'b1;
                                CMD_WRITE: sda_low <= last_bit ? 1'b0 : !shift_q[7];
                                default:   sda_low <= last_bit ? !ack_q : 1'b0;
                            endcase
                        end
                        2'd1: scl <= 1'b1;
                        2'd2:
                        begin
                            if (cmd_q == CMD_START)
                                sda_low <= 1'b1;   // sda falls, scl high
                            else if (cmd_q == CMD_STOP)
                                sda_low <= 1'b0;   // sda rises, scl high
                        end
                        default:
                        begin
                            if (last_bit)
                            begin
                                active   <= 1'b0;  // scl stays high when idle
                                cmd_done <= 1'b1;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 4'd1;
                                scl     <= 1'b0;
                            end
                        end
                    endcase
                end
            end
        end
    end

    // shift register and sampled results
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            shift_q <= tx_byte;
            ack_q   <= tx_ack_bit;
        end
        else if (qtr_end && (qtr == 2'd2) && is_byte)
        begin
            // sample at mid scl high
            if (!last_bit)
                shift_q <= {shift_q[6:0], sda_in};
            else if (cmd_q == CMD_WRITE)
                rx_ack <= sda_in;   // 0 means the slave acknowledged
        end

        if (qtr_end && (qtr == 2'd3) && last_bit && (cmd_q == CMD_READ))
            rx_byte <= shift_q;
    end

endmodule

`default_nettype wire

// File: design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 24C16 style device type code, first nibble of every control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

    // CLK cycles per quarter of an SCL period
    localparam int QTR_CYCLES = 2;

    // width of the quarter cycle counter
    localparam int QTR_W = (QTR_CYCLES > 1) ? $clog2(QTR_CYCLES) : 1;

    // bit index of the acknowledge slot inside a byte transfer
    localparam int ACK_BIT = 8;

    // 11-bit byte address, top three bits are the block bits
    typedef logic [10:0] ee_addr_t;

    // data or control byte
    typedef logic [7:0] ee_byte_t;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

endpackage

`default_nettype wire
